//--- Bender.yml
package:
  name: fmac_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fmac_pkg.sv
      - verilog/fmac_fifo.sv
      - verilog/tx_xgmii_encap.sv
      - verilog/rx_xgmii_decap.sv
      - verilog/fmac_stats.sv
      - verilog/fmac_core.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/fmac_core_tb.sv

//--- fmac_core.f
+incdir+verilog
+incdir+test
verilog/fmac_pkg.sv
verilog/fmac_fifo.sv
verilog/tx_xgmii_encap.sv
verilog/rx_xgmii_decap.sv
verilog/fmac_stats.sv
verilog/fmac_core.sv
test/fmac_core_tb.sv

//--- test/fmac_core_tb_table.svh
/* fmac core test table
   one packet per row with its filter setup and expected outcome */
`ifndef FMAC_CORE_TB_TABLE_SVH
`define FMAC_CORE_TB_TABLE_SVH

localparam int NUM_ROWS = 21;

// columns: is_rx, len, dest, bcast_en, prom_mode, hold_rd, outcome
localparam row_t ROWS [NUM_ROWS] = '{
	'{1'b0, 5'd1,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},  // tx single beat
	'{1'b0, 5'd4,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},
	'{1'b0, 5'd16, DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},  // tx max packet
	'{1'b1, 5'd1,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},  // start and last on one word
	'{1'b1, 5'd5,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},
	'{1'b1, 5'd3,  DEST_OTHER, 1'b0, 1'b0, 1'b0, OUT_FILT},    // foreign unicast
	'{1'b1, 5'd4,  DEST_BCAST, 1'b0, 1'b0, 1'b0, OUT_FILT},    // broadcast disabled
	'{1'b1, 5'd4,  DEST_BCAST, 1'b1, 1'b0, 1'b0, OUT_ACCEPT},
	'{1'b1, 5'd2,  DEST_OTHER, 1'b0, 1'b1, 1'b0, OUT_ACCEPT},  // promiscuous
	'{1'b1, 5'd6,  DEST_BCAST, 1'b0, 1'b1, 1'b0, OUT_ACCEPT},
	'{1'b0, 5'd7,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},
	// rx_rd held low from here, FIFO fills 16, 32, 48, 56
	'{1'b1, 5'd16, DEST_OWN,   1'b0, 1'b0, 1'b1, OUT_ACCEPT},
	'{1'b1, 5'd16, DEST_OWN,   1'b0, 1'b0, 1'b1, OUT_ACCEPT},
	'{1'b1, 5'd16, DEST_BCAST, 1'b1, 1'b0, 1'b1, OUT_ACCEPT},
	'{1'b1, 5'd8,  DEST_OWN,   1'b0, 1'b0, 1'b1, OUT_ACCEPT},  // exactly 16 words free
	'{1'b1, 5'd4,  DEST_OWN,   1'b0, 1'b0, 1'b1, OUT_OVR},     // only 8 free
	'{1'b1, 5'd2,  DEST_OTHER, 1'b0, 1'b0, 1'b1, OUT_FILT},    // filter before overrun
	'{1'b1, 5'd16, DEST_OTHER, 1'b0, 1'b1, 1'b1, OUT_OVR},
	// drained again before each packet
	'{1'b1, 5'd3,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},
	'{1'b0, 5'd2,  DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT},
	'{1'b1, 5'd16, DEST_OWN,   1'b0, 1'b0, 1'b0, OUT_ACCEPT}
};

`endif

//--- test/fmac_core_tb.sv
/* fmac core testbench
   table driven checks of tx framing, rx filtering, overrun drop and statistics */
`include "fmac_config.svh"

module fmac_core_tb;
	import fmac_pkg::*;

	localparam int DRIVE_DLY     = 10;              // after rising edge
	localparam int TIMEOUT_SLACK = 1000;
	localparam logic [1:0] DEST_OWN   = 2'd0;
	localparam logic [1:0] DEST_OTHER = 2'd1;
	localparam logic [1:0] DEST_BCAST = 2'd2;
	localparam logic [1:0] OUT_ACCEPT = 2'd0;
	localparam logic [1:0] OUT_FILT   = 2'd1;       // address filter drop
	localparam logic [1:0] OUT_OVR    = 2'd2;       // overrun drop
	localparam logic [47:0] OWN_MAC   = 48'h02_1a_3c_5e_7f_90;

	typedef struct packed {
		logic       is_rx;
		logic [4:0] len;                            // beats
		logic [1:0] dest;
		logic       bcast_en;
		logic       prom_mode;
		logic       hold_rd;                        // leave rx_rd low, no drain
		logic [1:0] outcome;
	} row_t;

	`include "fmac_core_tb_table.svh"

	logic                    usr_clk;
	logic                    usr_rst_;
	logic                    tx_wr;
	pkt_word_t               tx_din;
	logic                    tx_full;
	xgmii_t                  xgmii_rx;
	xgmii_t                  xgmii_tx;
	logic [47:0]             mac_addr;
	logic                    bcast_en;
	logic                    prom_mode;
	logic                    rx_rd;
	pkt_word_t               rx_dout;
	logic                    rx_empty;
	stat_sel_e               stat_addr;
	logic                    stat_clr;
	logic [`FMAC_STAT_W-1:0] stat_dout;

	logic [31:0]             lfsr;                  // payload generator state
	logic [`FMAC_STAT_W-1:0] model_cnt [6];         // indexed by stat_sel_e
	pkt_word_t               rx_exp [$];            // words still owed by rx_dout
	pkt_word_t               pkt [$];               // current packet

	fmac_core DUT (.*);

	initial
	begin
		usr_clk = 1'b0;
		forever
			#50 usr_clk = ~usr_clk;
	end

	// ============================================================
	// expected beats and payload
	// ============================================================
	function automatic xgmii_t ctrl_beat(input logic [7:0] lane0);
		return '{d: {{7{`FMAC_XGMII_IDLE}}, lane0}, c: 8'hff};     // idle or terminate
	endfunction

	function automatic xgmii_t start_beat();
		return '{d: {`FMAC_XGMII_SFD, {6{`FMAC_XGMII_PRE}}, `FMAC_XGMII_START}, c: 8'h01};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);     // Galois, shift right
	endfunction

	function automatic int table_beats();
		int sum;
		sum = 0;
		for (int n = 0; n < NUM_ROWS; n++)
			sum += ROWS[n].len + 8;                 // framing, gap, drain
		return sum;
	endfunction

	task automatic random_word(output logic [63:0] w);
		for (int i = 0; i < 64; i++)
		begin
			w    = {w[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);                 // one step per bit
		end
	endtask

	task automatic make_packet(input row_t r);
		logic [63:0] w;
		logic [47:0] dest;
		pkt_word_t   word;
		case (r.dest)
		DEST_OWN:   dest = OWN_MAC;
		DEST_OTHER: dest = OWN_MAC ^ 48'h1;         // one bit off
		default:    dest = '1;
		endcase
		pkt.delete();
		for (int i = 0; i < r.len; i++)
		begin
			random_word(w);
			if (i == 0)
				w[47:0] = dest;
			word.data  = w;
			word.start = (i == 0);
			word.last  = (i == r.len - 1);
			pkt.push_back(word);
		end
	endtask

	// ============================================================
	// checks
	// ============================================================
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_beat(input xgmii_t got, input xgmii_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("error %0t: %s beat d=%h c=%h, expected d=%h c=%h",
				$time, what, got.d, got.c, exp.d, exp.c));
	endtask

	task automatic check_word(input pkt_word_t got, input pkt_word_t exp);
		if (got !== exp)
			abort_run($sformatf("error %0t: rx word %h start %b last %b, expected %h %b %b",
				$time, got.data, got.start, got.last, exp.data, exp.start, exp.last));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("error %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_count(input stat_sel_e sel, input logic [`FMAC_STAT_W-1:0] exp);
		@(posedge usr_clk);
		#DRIVE_DLY stat_addr = sel;
		@(posedge usr_clk);                         // registered read
		@(negedge usr_clk);
		if (stat_dout !== exp)
			abort_run($sformatf("error %0t: counter %s is %0d, expected %0d",
				$time, sel.name(), stat_dout, exp));
	endtask

	// ============================================================
	// transmit and receive drivers
	// ============================================================
	task automatic run_tx();
		xgmii_t b;
		foreach (pkt[i])
		begin
			@(posedge usr_clk);
			#DRIVE_DLY;
			tx_wr  = 1'b1;
			tx_din = pkt[i];
		end
		@(posedge usr_clk);
		#DRIVE_DLY tx_wr = 1'b0;
		@(negedge usr_clk);
		while (xgmii_tx === ctrl_beat(`FMAC_XGMII_IDLE))   // latency varies
			@(negedge usr_clk);
		check_beat(xgmii_tx, start_beat(), "tx start");
		foreach (pkt[i])
		begin
			@(negedge usr_clk);
			b.d = pkt[i].data;
			b.c = '0;
			check_beat(xgmii_tx, b, "tx data");
		end
		@(negedge usr_clk);
		check_beat(xgmii_tx, ctrl_beat(`FMAC_XGMII_TERM), "tx terminate");
		@(negedge usr_clk);
		check_beat(xgmii_tx, ctrl_beat(`FMAC_XGMII_IDLE), "tx gap");
		model_cnt[STAT_TX_PKT]  += 1;
		model_cnt[STAT_TX_BYTE] += 8 * pkt.size();
	endtask

	task automatic send_beat(input xgmii_t b);
		@(posedge usr_clk);
		#DRIVE_DLY xgmii_rx = b;
	endtask

	task automatic run_rx(input row_t r);
		xgmii_t b;
		@(posedge usr_clk);
		#DRIVE_DLY;
		bcast_en  = r.bcast_en;
		prom_mode = r.prom_mode;
		send_beat(start_beat());
		foreach (pkt[i])
		begin
			b.d = pkt[i].data;
			b.c = '0;
			send_beat(b);
		end
		send_beat(ctrl_beat(`FMAC_XGMII_TERM));
		repeat (2)
			send_beat(ctrl_beat(`FMAC_XGMII_IDLE));   // last word lands in FIFO
		case (r.outcome)
		OUT_ACCEPT:
		begin
			foreach (pkt[i])
				rx_exp.push_back(pkt[i]);
			model_cnt[STAT_RX_PKT]  += 1;
			model_cnt[STAT_RX_BYTE] += 8 * pkt.size();
		end
		OUT_FILT: model_cnt[STAT_RX_FILT_DROP] += 1;
		default:  model_cnt[STAT_RX_OVR_DROP]  += 1;
		endcase
	endtask

	task automatic drain_rx();
		while (rx_exp.size() > 0)
		begin
			@(negedge usr_clk);
			if (!rx_empty)
			begin
				check_word(rx_dout, rx_exp.pop_front());
				@(posedge usr_clk);
				#DRIVE_DLY rx_rd = 1'b1;
				@(posedge usr_clk);
				#DRIVE_DLY rx_rd = 1'b0;
			end
		end
		@(negedge usr_clk);
		if (!rx_empty)
			abort_run("the receive FIFO still holds words after every expected packet was read");
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial
	begin
		lfsr      = 32'hf2c7_1914;
		usr_rst_  = 1'b0;
		tx_wr     = 1'b0;
		tx_din    = '0;
		xgmii_rx  = ctrl_beat(`FMAC_XGMII_IDLE);
		mac_addr  = OWN_MAC;
		bcast_en  = 1'b0;
		prom_mode = 1'b0;
		rx_rd     = 1'b0;
		stat_addr = STAT_TX_PKT;
		stat_clr  = 1'b0;
		foreach (model_cnt[i])
			model_cnt[i] = '0;
		repeat (2)
			@(posedge usr_clk);
		#DRIVE_DLY usr_rst_ = 1'b1;
		@(negedge usr_clk);
		check_beat(xgmii_tx, ctrl_beat(`FMAC_XGMII_IDLE), "after reset");
		check_flag(rx_empty, 1'b1, "rx_empty after reset");
		check_flag(tx_full, 1'b0, "tx_full after reset");
		check_flag(stat_dout == '0, 1'b1, "stat_dout zero after reset");
		for (int n = 0; n < NUM_ROWS; n++)
		begin
			make_packet(ROWS[n]);
			if (!ROWS[n].is_rx)
				run_tx();
			else
			begin
				if (!ROWS[n].hold_rd)
					drain_rx();                     // backlog from held rows
				run_rx(ROWS[n]);
				if (!ROWS[n].hold_rd)
					drain_rx();
			end
		end
		drain_rx();
		foreach (model_cnt[i])
			check_count(stat_sel_e'(i), model_cnt[i]);
		@(posedge usr_clk);
		#DRIVE_DLY stat_clr = 1'b1;
		@(posedge usr_clk);
		#DRIVE_DLY stat_clr = 1'b0;
		foreach (model_cnt[i])
			check_count(stat_sel_e'(i), '0);       // all cleared together
		$display("all tests passed");
		$finish;
	end

	initial
	begin
		int limit;
		int cycles;
		limit  = table_beats() * 4 + TIMEOUT_SLACK;
		cycles = 0;
		forever
		begin
			@(posedge usr_clk);
			cycles++;
			if (cycles >= limit)
				abort_run($sformatf("timeout, the run did not finish within %0d clock cycles",
					limit));
		end
	end

endmodule

//--- verilog/fmac_config.svh
/* fmac configuration
   beat widths, FIFO depths, packet limit and XGMII control codes */
`ifndef FMAC_CONFIG_SVH
`define FMAC_CONFIG_SVH

// ============================================================
// data path widths
// ============================================================
`define FMAC_DATA_W         64      // bits per XGMII beat
`define FMAC_CTRL_W         8       // one control bit per byte lane

// ============================================================
// buffering and packet limits
// ============================================================
`define FMAC_TX_DEPTH       64      // transmit FIFO words
`define FMAC_RX_DEPTH       64      // receive FIFO words
`define FMAC_MAX_PKT_WORDS  16      // longest packet, in beats
`define FMAC_STAT_W         32      // statistics counter width

// ============================================================
// XGMII control codes and preamble bytes
// ============================================================
`define FMAC_XGMII_IDLE     8'h07   // idle, fills inter-packet gap
`define FMAC_XGMII_START    8'hFB   // start, always lane 0 here
`define FMAC_XGMII_TERM     8'hFD   // terminate, lane 0 after last data beat
`define FMAC_XGMII_PRE      8'h55   // preamble byte
`define FMAC_XGMII_SFD      8'hD5   // start of frame delimiter

`endif

//--- verilog/fmac_core.sv
/* fmac core top level
   transmit encapsulator, receive decapsulator, receive FIFO and statistics */
`include "fmac_config.svh"

module fmac_core (
	input  logic                     usr_clk,
	input  logic                     usr_rst_,

	// transmit packet input
	input  logic                     tx_wr,
	input  fmac_pkg::pkt_word_t      tx_din,
	output logic                     tx_full,

	// XGMII
	input  fmac_pkg::xgmii_t         xgmii_rx,
	output fmac_pkg::xgmii_t         xgmii_tx,

	// configuration
	input  logic [47:0]              mac_addr,
	input  logic                     bcast_en,
	input  logic                     prom_mode,

	// receive packet output
	input  logic                     rx_rd,
	output fmac_pkg::pkt_word_t      rx_dout,
	output logic                     rx_empty,

	// statistics read
	input  fmac_pkg::stat_sel_e      stat_addr,
	input  logic                     stat_clr,
	output logic [`FMAC_STAT_W-1:0]  stat_dout
);
	import fmac_pkg::*;

	localparam int RX_CNT_W = $clog2(`FMAC_RX_DEPTH + 1);

	stat_evt_t              tx_evt;
	stat_evt_t              rx_evt;
	stat_evt_t              evt;            // merged event pulses
	logic                   rxq_wr;
	pkt_word_t              rxq_din;
	logic [RX_CNT_W-1:0]    rxq_count;

	// ============================================================
	// transmit path
	// ============================================================
	tx_xgmii_encap tx_encap (
		.usr_clk  (usr_clk),
		.usr_rst_ (usr_rst_),
		.tx_wr    (tx_wr),
		.tx_din   (tx_din),
		.tx_full  (tx_full),
		.xgmii_tx (xgmii_tx),
		.tx_evt   (tx_evt)              // tx fields only
	);

	// ============================================================
	// receive path
	// ============================================================
	rx_xgmii_decap rx_decap (
		.usr_clk   (usr_clk),
		.usr_rst_  (usr_rst_),
		.xgmii_rx  (xgmii_rx),
		.mac_addr  (mac_addr),
		.bcast_en  (bcast_en),
		.prom_mode (prom_mode),
		.rxq_count (rxq_count),         // fill level for overrun check
		.rxq_wr    (rxq_wr),
		.rxq_din   (rxq_din),
		.rx_evt    (rx_evt)             // rx fields only
	);

	fmac_fifo #(.DEPTH(`FMAC_RX_DEPTH)) rx_fifo (
		.usr_clk  (usr_clk),
		.usr_rst_ (usr_rst_),
		.wr       (rxq_wr),
		.din      (rxq_din),
		.rd       (rx_rd),
		.dout     (rx_dout),
		.empty    (rx_empty),
		.full     (),                   // decap keeps max packet of headroom
		.count    (rxq_count)
	);

	assign evt = tx_evt | rx_evt;       // fields never overlap

	fmac_stats stats (
		.usr_clk   (usr_clk),
		.usr_rst_  (usr_rst_),
		.evt       (evt),
		.stat_clr  (stat_clr),
		.stat_addr (stat_addr),
		.stat_dout (stat_dout)
	);

endmodule

//--- verilog/fmac_fifo.sv
/* packet word FIFO
   single clock, first-word-fall-through, with occupancy count */
module fmac_fifo #(
	parameter int DEPTH = 64
) (
	input  logic                         usr_clk,
	input  logic                         usr_rst_,
	input  logic                         wr,
	input  fmac_pkg::pkt_word_t          din,
	input  logic                         rd,
	output fmac_pkg::pkt_word_t          dout,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   count
);
	import fmac_pkg::*;

	localparam int AW = $clog2(DEPTH);

	pkt_word_t      mem [DEPTH];            // storage
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic           do_wr;
	logic           do_rd;

	assign do_wr = wr && !full;             // write while full dropped
	assign do_rd = rd && !empty;            // read while empty ignored
	assign empty = (count == '0);
	assign full  = (count == DEPTH);
	assign dout  = mem[rd_ptr];             // head word always presented

	always_ff @(posedge usr_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	// ============================================================
	// pointers and occupancy
	// ============================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;        // idle or push+pop
			endcase
		end
	end

endmodule

//--- verilog/fmac_pkg.sv
/* fmac shared types
   XGMII beat, FIFO word, statistics events, counter select and FSM states */
`include "fmac_config.svh"

package fmac_pkg;

	// ============================================================
	// bus structs
	// ============================================================
	typedef struct packed {
		logic [`FMAC_DATA_W-1:0] d;     // lane 0 in bits 7:0
		logic [`FMAC_CTRL_W-1:0] c;     // 1 = control lane
	} xgmii_t;

	typedef struct packed {
		logic [`FMAC_DATA_W-1:0] data;  // one 8-byte beat
		logic                    start; // first word of packet, rx only
		logic                    last;  // final word of packet
	} pkt_word_t;

	typedef struct packed {
		logic tx_pkt;                   // terminate beat sent
		logic tx_beat;                  // data beat sent
		logic rx_pkt;                   // accepted packet completed
		logic rx_beat;                  // accepted beat written
		logic rx_filt_drop;             // address filter reject
		logic rx_ovr_drop;              // no room for max packet
	} stat_evt_t;

	// ============================================================
	// enums
	// ============================================================
	typedef enum logic [2:0] {
		STAT_TX_PKT,
		STAT_TX_BYTE,
		STAT_RX_PKT,
		STAT_RX_BYTE,
		STAT_RX_FILT_DROP,
		STAT_RX_OVR_DROP
	} stat_sel_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_TERM} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_FIRST, RX_ACCEPT, RX_DISCARD} rx_state_e;

	// fixed framing beats
	localparam xgmii_t XGMII_IDLE_BEAT = '{
		d: {8{`FMAC_XGMII_IDLE}},
		c: {`FMAC_CTRL_W{1'b1}}
	};
	localparam xgmii_t XGMII_START_BEAT = '{
		d: {`FMAC_XGMII_SFD, {6{`FMAC_XGMII_PRE}}, `FMAC_XGMII_START},
		c: `FMAC_CTRL_W'(1)                 // only lane 0 is control
	};
	localparam xgmii_t XGMII_TERM_BEAT = '{
		d: {{7{`FMAC_XGMII_IDLE}}, `FMAC_XGMII_TERM},
		c: {`FMAC_CTRL_W{1'b1}}
	};

endpackage

//--- verilog/fmac_stats.sv
/* statistics counters
   packet, byte and drop counts with common clear and registered read */
`include "fmac_config.svh"

module fmac_stats (
	input  logic                     usr_clk,
	input  logic                     usr_rst_,
	input  fmac_pkg::stat_evt_t      evt,
	input  logic                     stat_clr,
	input  fmac_pkg::stat_sel_e      stat_addr,
	output logic [`FMAC_STAT_W-1:0]  stat_dout
);
	import fmac_pkg::*;

	localparam int STAT_NUM = 6;

	logic [`FMAC_STAT_W-1:0]  cnt  [STAT_NUM];  // indexed by stat_sel_e
	logic [3:0]               step [STAT_NUM];  // amount added this cycle

	always_comb
	begin
		step[STAT_TX_PKT]       = {3'd0, evt.tx_pkt};
		step[STAT_TX_BYTE]      = evt.tx_beat ? 4'd8 : 4'd0;    // 8 bytes per beat
		step[STAT_RX_PKT]       = {3'd0, evt.rx_pkt};
		step[STAT_RX_BYTE]      = evt.rx_beat ? 4'd8 : 4'd0;
		step[STAT_RX_FILT_DROP] = {3'd0, evt.rx_filt_drop};
		step[STAT_RX_OVR_DROP]  = {3'd0, evt.rx_ovr_drop};
	end

	// ============================================================
	// counters, wrap on overflow
	// ============================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_ || stat_clr)
		begin
			for (int i = 0; i < STAT_NUM; i++)
				cnt[i] <= '0;               // events this cycle are lost
		end
		else
		begin
			for (int i = 0; i < STAT_NUM; i++)
				cnt[i] <= cnt[i] + `FMAC_STAT_W'(step[i]);
		end
	end

	// read mux, one cycle behind stat_addr
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
			stat_dout <= '0;
		else if (stat_addr < STAT_NUM)
			stat_dout <= cnt[stat_addr];
		else
			stat_dout <= '0;                // unused codes read zero
	end

endmodule

//--- verilog/rx_xgmii_decap.sv
/* receive decapsulator
   strips XGMII framing, filters on destination and drops on FIFO overrun */
`include "fmac_config.svh"

module rx_xgmii_decap (
	input  logic                                  usr_clk,
	input  logic                                  usr_rst_,
	input  fmac_pkg::xgmii_t                      xgmii_rx,
	input  logic [47:0]                           mac_addr,
	input  logic                                  bcast_en,
	input  logic                                  prom_mode,
	input  logic [$clog2(`FMAC_RX_DEPTH+1)-1:0]   rxq_count,
	output logic                                  rxq_wr,
	output fmac_pkg::pkt_word_t                   rxq_din,
	output fmac_pkg::stat_evt_t                   rx_evt
);
	import fmac_pkg::*;

	localparam int CNT_W = $clog2(`FMAC_RX_DEPTH + 1);

	rx_state_e                  state;
	logic [`FMAC_DATA_W-1:0]    hold_data;      // beat waiting for its successor
	logic                       hold_first;     // held beat is first of packet
	logic                       is_start;
	logic                       is_term;
	logic [47:0]                dest;
	logic                       addr_ok;
	logic                       room_ok;
	logic [CNT_W-1:0]           free_words;

	// ============================================================
	// beat decode and packet judgement
	// ============================================================
	assign is_start   = xgmii_rx.c[0] && (xgmii_rx.d[7:0] == `FMAC_XGMII_START);
	assign is_term    = xgmii_rx.c[0] && (xgmii_rx.d[7:0] == `FMAC_XGMII_TERM);
	assign dest       = xgmii_rx.d[47:0];     // valid in RX_FIRST
	assign addr_ok    = prom_mode || (dest == mac_addr) || (bcast_en && (&dest));
	assign free_words = CNT_W'(`FMAC_RX_DEPTH) - rxq_count;
	assign room_ok    = (free_words >= CNT_W'(`FMAC_MAX_PKT_WORDS));

	// held beat goes out as the next beat shows up
	assign rxq_wr  = (state == RX_ACCEPT);
	assign rxq_din = '{data: hold_data, start: hold_first, last: is_term};

	always_comb
	begin
		rx_evt              = '0;
		rx_evt.rx_beat      = rxq_wr;
		rx_evt.rx_pkt       = rxq_wr && is_term;
		rx_evt.rx_filt_drop = (state == RX_FIRST) && !addr_ok;
		rx_evt.rx_ovr_drop  = (state == RX_FIRST) && addr_ok && !room_ok;   // filter wins
	end

	always_ff @(posedge usr_clk)
	begin
		if ((state == RX_FIRST) || (state == RX_ACCEPT))
			hold_data <= xgmii_rx.d;
	end

	// ============================================================
	// packet FSM
	// ============================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			state      <= RX_IDLE;
			hold_first <= 1'b0;
		end
		else
		begin
			case (state)
			RX_IDLE:
			begin
				if (is_start)
					state <= RX_FIRST;
			end
			RX_FIRST:
			begin
				hold_first <= 1'b1;
				if (addr_ok && room_ok)
					state <= RX_ACCEPT;     // whole packet now fits
				else
					state <= RX_DISCARD;
			end
			RX_ACCEPT:
			begin
				hold_first <= 1'b0;
				if (is_term)
					state <= RX_IDLE;
			end
			RX_DISCARD:
			begin
				if (is_term)
					state <= RX_IDLE;       // swallow rest of packet
			end
			default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/tx_xgmii_encap.sv
/* transmit encapsulator
   buffers whole packets and frames them as start, data and terminate beats */
`include "fmac_config.svh"

module tx_xgmii_encap (
	input  logic                usr_clk,
	input  logic                usr_rst_,
	input  logic                tx_wr,
	input  fmac_pkg::pkt_word_t tx_din,
	output logic                tx_full,
	output fmac_pkg::xgmii_t    xgmii_tx,
	output fmac_pkg::stat_evt_t tx_evt
);
	import fmac_pkg::*;

	localparam int CNT_W = $clog2(`FMAC_TX_DEPTH + 1);

	pkt_word_t          q_dout;             // head of tx FIFO
	logic               q_empty;
	logic               q_pop;
	logic               pkt_in;             // last word accepted into FIFO
	logic               pkt_out;            // last word popped
	logic [CNT_W-1:0]   pkt_cnt;            // complete packets buffered
	tx_state_e          state;

	fmac_fifo #(.DEPTH(`FMAC_TX_DEPTH)) tx_fifo (
		.usr_clk  (usr_clk),
		.usr_rst_ (usr_rst_),
		.wr       (tx_wr),
		.din      (tx_din),                 // start flag unused on tx
		.rd       (q_pop),
		.dout     (q_dout),
		.empty    (q_empty),
		.full     (tx_full),
		.count    ()
	);

	assign q_pop   = (state == TX_DATA) && !q_empty;
	assign pkt_in  = tx_wr && !tx_full && tx_din.last;
	assign pkt_out = q_pop && q_dout.last;

	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
			pkt_cnt <= '0;
		else if (pkt_in && !pkt_out)
			pkt_cnt <= pkt_cnt + 1'b1;
		else if (pkt_out && !pkt_in)
			pkt_cnt <= pkt_cnt - 1'b1;
	end

	// ============================================================
	// framing FSM with beat registered onto xgmii_tx
	// ============================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			state    <= TX_IDLE;
			xgmii_tx <= XGMII_IDLE_BEAT;
			tx_evt   <= '0;
		end
		else
		begin
			tx_evt <= '0;                   // single cycle pulses
			case (state)
			TX_IDLE:
			begin
				xgmii_tx <= XGMII_IDLE_BEAT;    // also the gap after terminate
				if (pkt_cnt != '0)
					state <= TX_START;
			end
			TX_START:
			begin
				xgmii_tx <= XGMII_START_BEAT;
				state    <= TX_DATA;
			end
			TX_DATA:
			begin
				xgmii_tx       <= '{d: q_dout.data, c: '0};   // whole packet is buffered
				tx_evt.tx_beat <= 1'b1;
				if (q_dout.last)
					state <= TX_TERM;
			end
			TX_TERM:
			begin
				xgmii_tx      <= XGMII_TERM_BEAT;
				tx_evt.tx_pkt <= 1'b1;
				state         <= TX_IDLE;
			end
			default: state <= TX_IDLE;
			endcase
		end
	end

endmodule
